//--- Bender.yml
package:
  name: umode_checker

sources:
  - source/umode_pkg.sv
  - source/insn_decoder.sv
  - source/rule_checker.sv
  - source/mode_tracker.sv
  - source/violation_log.sv
  - source/umode_checker.sv
  - target: test
    files:
      - testbench/umode_checker_properties.sv
      - testbench/tb_umode_checker.sv

//--- source/insn_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module insn_decoder (
  input  wire logic [31:0]           insn,
  output umode_pkg::insn_class_e     insn_class
);

  import umode_pkg::*;

  logic is_system;
  logic is_custom;
  logic is_csr;

  assign is_system = (insn[6:0] == SYSTEM_OPCODE);

  assign is_custom = ((insn & CUSTOM0_IMASK) == CUSTOM0_IDATA) ||
                     ((insn & CUSTOM1_IMASK) == CUSTOM1_IDATA);

  // funct3 of 0 is the priv group, 4 is reserved
  assign is_csr = is_system && (insn[14:12] != 3'd0) && (insn[14:12] != 3'd4);

  always_comb begin
    if (insn == MRET_IDATA) begin
      insn_class = CLASS_MRET;
    end else if (insn == WFI_IDATA) begin
      insn_class = CLASS_WFI;
    end else if (insn == ECALL_IDATA) begin
      insn_class = CLASS_ECALL;
    end else if (insn == EBREAK_IDATA) begin
      insn_class = CLASS_EBREAK;
    end else if (insn == URET_IDATA) begin
      insn_class = CLASS_URET;
    end else if (is_custom) begin
      insn_class = CLASS_CUSTOM;
    end else if (is_csr && (insn[29:28] != 2'b00)) begin
      // csr address names a privilege above user
      insn_class = CLASS_CSR_HIGH;
    end else begin
      insn_class = CLASS_OTHER;
    end
  end

endmodule

`default_nettype wire

//--- source/mode_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module mode_tracker (
  input  wire logic                    clk_i,
  input  wire logic                    reset,
  input  wire logic                    retire_valid,
  input  wire umode_pkg::retire_t      retire,
  input  wire umode_pkg::insn_class_e  insn_class,
  output umode_pkg::violation_t        seq_viol
);

  import umode_pkg::*;

  logic       prev_trap;
  logic       prev_mret;
  priv_mode_e prev_mpp;
  logic       mret_to_resume;

  // a clean mret from machine mode resumes in mpp
  assign mret_to_resume = (insn_class == CLASS_MRET) && (retire.mode == MODE_M) &&
                          !retire.trap.trap;

  always_ff @(posedge clk_i) begin
    if (reset) begin
      prev_trap <= 1'b0;
      prev_mret <= 1'b0;
    end else if (retire_valid) begin
      prev_trap <= retire.trap.trap;
      prev_mret <= mret_to_resume;
    end
  end

  // mpp value, only meaningful while prev_mret is set
  always_ff @(posedge clk_i) begin
    if (retire_valid) begin
      prev_mpp <= priv_mode_e'(retire.mstatus_rdata[MPP_POS +: MPP_W]);
    end
  end

  always_comb begin
    seq_viol = '0;
    // handler runs in machine mode
    seq_viol[RULE_TRAP_TO_M]   = prev_trap && (retire.mode != MODE_M);
    seq_viol[RULE_MRET_TO_MPP] = prev_mret && (retire.mode != prev_mpp);
  end

endmodule

`default_nettype wire

//--- source/rule_checker.sv
`timescale 1ns/1ps
`default_nettype none

module rule_checker (
  input  wire umode_pkg::retire_t       retire,
  input  wire umode_pkg::insn_class_e   insn_class,
  output umode_pkg::violation_t         single_viol
);

  import umode_pkg::*;

  logic [31:0]      mstatus_post;
  logic [MPP_W-1:0] mpp_post;
  logic             in_umode;
  logic             tw;
  logic             is_illegal_exc;
  logic             is_ecall_exc;
  logic             must_be_illegal;

  // written bits under the mask, old bits elsewhere
  assign mstatus_post = (retire.mstatus_wdata & retire.mstatus_wmask) |
                        (retire.mstatus_rdata & ~retire.mstatus_wmask);
  assign mpp_post = mstatus_post[MPP_POS +: MPP_W];

  assign in_umode = (retire.mode == MODE_U);
  assign tw       = retire.mstatus_rdata[TW_POS];

  assign is_illegal_exc = retire.trap.trap && retire.trap.exception &&
                          (retire.trap.cause == EXC_ILLEGAL);
  assign is_ecall_exc   = retire.trap.trap && retire.trap.exception &&
                          (retire.trap.cause == EXC_ECALL_U);

  assign must_be_illegal = (insn_class == CLASS_URET) ||
                           (insn_class == CLASS_CUSTOM) ||
                           (in_umode && (insn_class == CLASS_MRET)) ||
                           (in_umode && (insn_class == CLASS_CSR_HIGH));

  always_comb begin
    single_viol = '0;

    single_viol[RULE_MODE_SUPPORTED] = (retire.mode == MODE_S) || (retire.mode == MODE_R);

    single_viol[RULE_MSCRATCH] = in_umode && (retire.mscratch_wmask != '0);

    // mpp may only hold U or M
    single_viol[RULE_MPP_LEGAL] = (mpp_post != MODE_U) && (mpp_post != MODE_M);

    single_viol[RULE_UMODE_MPRV] = in_umode && retire.mstatus_rdata[MPRV_POS];

    // wfi in user mode traps exactly when tw is set
    if ((insn_class == CLASS_WFI) && in_umode) begin
      single_viol[RULE_WFI_TW] = tw ? !is_illegal_exc : is_illegal_exc;
    end

    single_viol[RULE_ECALL] = (insn_class == CLASS_ECALL) && in_umode && !is_ecall_exc;

    single_viol[RULE_MUST_ILLEGAL] = must_be_illegal && !is_illegal_exc;
  end

endmodule

`default_nettype wire

//--- source/umode_checker.sv
`timescale 1ns/1ps
`default_nettype none

module umode_checker (
  input  wire logic                      clk_i,
  input  wire logic                      reset,
  input  wire logic                      retire_valid,
  input  wire umode_pkg::retire_t        retire,
  input  wire logic                      log_clear,
  output umode_pkg::violation_t          violation,
  output umode_pkg::violation_t          violation_sticky,
  output logic [umode_pkg::COUNT_W-1:0]  violation_count
);

  import umode_pkg::*;

  insn_class_e insn_class;
  violation_t  single_viol;
  violation_t  seq_viol;

  insn_decoder i_insn_decoder (
    .insn       (retire.insn),
    .insn_class (insn_class)
  );

  rule_checker i_rule_checker (
    .retire      (retire),
    .insn_class  (insn_class),
    .single_viol (single_viol)
  );

  // rules that span two retirements
  mode_tracker i_mode_tracker (
    .clk_i        (clk_i),
    .reset        (reset),
    .retire_valid (retire_valid),
    .retire       (retire),
    .insn_class   (insn_class),
    .seq_viol     (seq_viol)
  );

  violation_log i_violation_log (
    .clk_i            (clk_i),
    .reset            (reset),
    .retire_valid     (retire_valid),
    .log_clear        (log_clear),
    .single_viol      (single_viol),
    .seq_viol         (seq_viol),
    .violation        (violation),
    .violation_sticky (violation_sticky),
    .violation_count  (violation_count)
  );

endmodule

`default_nettype wire

//--- source/umode_pkg.sv
`default_nettype none

package umode_pkg;

  // privilege modes, only U and M are implemented
  typedef enum logic [1:0] {
    MODE_U = 2'd0,
    MODE_S = 2'd1,
    MODE_R = 2'd2,
    MODE_M = 2'd3
  } priv_mode_e;

  typedef enum logic [2:0] {
    CLASS_OTHER,
    CLASS_MRET,
    CLASS_WFI,
    CLASS_ECALL,
    CLASS_EBREAK,
    CLASS_URET,
    CLASS_CUSTOM,
    CLASS_CSR_HIGH
  } insn_class_e;

  typedef struct packed {
    logic       trap;
    logic       exception;
    logic [5:0] cause;
  } trap_t;

  // one retired instruction as seen on the trace port
  typedef struct packed {
    priv_mode_e  mode;
    logic [31:0] insn;
    trap_t       trap;
    logic [31:0] mstatus_rdata;
    logic [31:0] mstatus_wdata;
    logic [31:0] mstatus_wmask;
    logic [31:0] mscratch_wmask;
  } retire_t;

  // bit index of each rule in the violation vector
  typedef enum logic [3:0] {
    RULE_MODE_SUPPORTED = 4'd0,
    RULE_MSCRATCH       = 4'd1,
    RULE_MPP_LEGAL      = 4'd2,
    RULE_UMODE_MPRV     = 4'd3,
    RULE_WFI_TW         = 4'd4,
    RULE_ECALL          = 4'd5,
    RULE_MUST_ILLEGAL   = 4'd6,
    RULE_TRAP_TO_M      = 4'd7,
    RULE_MRET_TO_MPP    = 4'd8
  } rule_e;

  localparam int NUM_RULES = 9;
  localparam int COUNT_W   = 8;

  typedef logic [NUM_RULES-1:0] violation_t;

  // mstatus fields
  localparam int MPP_POS  = 11;
  localparam int MPP_W    = 2;
  localparam int MPRV_POS = 17;
  localparam int TW_POS   = 21;

  localparam logic [6:0]  SYSTEM_OPCODE = 7'b1110011;
  localparam logic [31:0] MRET_IDATA    = 32'b0011000_00010_00000_000_00000_1110011;
  localparam logic [31:0] WFI_IDATA     = 32'b0001000_00101_00000_000_00000_1110011;
  localparam logic [31:0] ECALL_IDATA   = 32'b000000000000_00000_000_00000_1110011;
  localparam logic [31:0] EBREAK_IDATA  = 32'b000000000001_00000_000_00000_1110011;
  localparam logic [31:0] URET_IDATA    = 32'b0000000_00010_00000_000_00000_1110011;

  // custom system opcodes, matched under mask
  localparam logic [31:0] CUSTOM0_IDATA = 32'b100011_00000000000_000_00000_1110011;
  localparam logic [31:0] CUSTOM0_IMASK = 32'b111111_00000000000_111_00000_1111111;
  localparam logic [31:0] CUSTOM1_IDATA = 32'b110011_00000000000_000_00000_1110011;
  localparam logic [31:0] CUSTOM1_IMASK = 32'b111111_00000000000_111_00000_1111111;

  localparam logic [5:0] EXC_ILLEGAL = 6'd2;
  localparam logic [5:0] EXC_ECALL_U = 6'd8;

endpackage

`default_nettype wire

//--- source/violation_log.sv
`timescale 1ns/1ps
`default_nettype none

module violation_log (
  input  wire logic                         clk_i,
  input  wire logic                         reset,
  input  wire logic                         retire_valid,
  input  wire logic                         log_clear,
  input  wire umode_pkg::violation_t        single_viol,
  input  wire umode_pkg::violation_t        seq_viol,
  output umode_pkg::violation_t             violation,
  output umode_pkg::violation_t             violation_sticky,
  output logic [umode_pkg::COUNT_W-1:0]     violation_count
);

  import umode_pkg::*;

  localparam logic [COUNT_W-1:0] COUNT_MAX = {COUNT_W{1'b1}};

  violation_t         merged;
  logic               hit;
  violation_t         sticky_base;
  logic [COUNT_W-1:0] count_base;

  assign merged = retire_valid ? (single_viol | seq_viol) : '0;
  assign hit    = |merged;

  // a clear still keeps whatever is reported at the same edge
  assign sticky_base = log_clear ? '0 : violation_sticky;
  assign count_base  = log_clear ? '0 : violation_count;

  always_ff @(posedge clk_i) begin
    if (reset) begin
      violation        <= '0;
      violation_sticky <= '0;
      violation_count  <= '0;
    end else begin
      violation        <= merged;
      violation_sticky <= sticky_base | merged;
      if (hit && (count_base != COUNT_MAX)) begin
        violation_count <= count_base + 1'b1;
      end else begin
        violation_count <= count_base;
      end
    end
  end

endmodule

`default_nettype wire

//--- testbench/tb_umode_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_umode_checker;

  import umode_pkg::*;

  localparam int N_LEGAL  = 150;
  localparam int N_INJECT = 60;
  localparam int N_CROSS  = 30;
  localparam int N_LONG   = 300;
  localparam int N_SAT    = 270;
  // worst case per step, idle gaps are at most 3 cycles
  localparam int MAX_CYCLES = N_LEGAL * 4 + (N_INJECT + 8) * 2 + N_CROSS * 10 +
                              N_LONG * 5 + N_SAT + 2;
  localparam int TIMEOUT_NS = (MAX_CYCLES + 200) * 4;

  logic               clk_i = 1'b0;
  logic               reset = 1'b1;
  logic               retire_valid = 1'b0;
  logic               log_clear = 1'b0;
  retire_t            retire = '0;
  violation_t         violation;
  violation_t         violation_sticky;
  logic [COUNT_W-1:0] violation_count;

  logic [31:0]        lfsr = 32'd88565;
  violation_t         exp_viol = '0;
  violation_t         exp_sticky = '0;
  logic [COUNT_W-1:0] exp_count = '0;
  logic               m_prev_trap = 1'b0;
  logic               m_prev_mret = 1'b0;
  priv_mode_e         m_prev_mpp = MODE_U;
  int                 test_errors = 0;
  int                 tests_run = 0;
  int                 tests_failed = 0;

  umode_checker i_dut (
    .clk_i            (clk_i),
    .reset            (reset),
    .retire_valid     (retire_valid),
    .retire           (retire),
    .log_clear        (log_clear),
    .violation        (violation),
    .violation_sticky (violation_sticky),
    .violation_count  (violation_count)
  );

  always #2 clk_i = ~clk_i;

  // x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    repeat (n) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  task automatic gen_legal(input int mode_sel, input int kind_sel, output retire_t r,
                           output insn_class_e c);
    int          kind;
    logic [31:0] w;
    logic        u;
    w = rand_bits(32);
    if (mode_sel >= 0) r.mode = priv_mode_e'(mode_sel);
    else if (m_prev_trap) r.mode = MODE_M;
    else if (m_prev_mret) r.mode = m_prev_mpp;
    else r.mode = rand_bits(1) ? MODE_M : MODE_U;
    u = (r.mode == MODE_U);
    kind = (kind_sel >= 0) ? kind_sel : int'(rand_bits(3));
    // no legal mret or machine csr access in user mode
    if (u && (kind == 4 || kind == 5)) kind = 1;
    r.mstatus_rdata = rand_bits(32);
    r.mstatus_wdata = rand_bits(32);
    r.mstatus_wmask = rand_bits(32);
    r.mstatus_rdata[MPP_POS +: 2] = rand_bits(1) ? 2'b11 : 2'b00;
    r.mstatus_wdata[MPP_POS +: 2] = rand_bits(1) ? 2'b11 : 2'b00;
    r.mstatus_wmask[MPP_POS +: 2] = rand_bits(1) ? 2'b11 : 2'b00;
    if (u) r.mstatus_rdata[MPRV_POS] = 1'b0;
    r.mscratch_wmask = u ? 32'h0 : rand_bits(32);
    r.trap = '0;
    c = CLASS_OTHER;
    r.insn = {w[31:7], 7'b0110011};
    case (kind)
      1: r.insn = {w[31:30], 2'b00, w[27:15], 3'b010, w[11:7], 7'b1110011};
      2: begin
        r.insn = ECALL_IDATA;
        c = CLASS_ECALL;
        r.trap = {2'b11, u ? EXC_ECALL_U : 6'd11};
      end
      3: begin
        r.insn = WFI_IDATA;
        c = CLASS_WFI;
        // user wfi traps as illegal when tw is set
        if (u && r.mstatus_rdata[TW_POS]) r.trap = {2'b11, EXC_ILLEGAL};
      end
      4: begin
        r.insn = MRET_IDATA;
        c = CLASS_MRET;
      end
      5: begin
        r.insn = {w[31:30], 2'b11, w[27:15], 3'b010, w[11:7], 7'b1110011};
        c = CLASS_CSR_HIGH;
      end
      7: r.trap = {1'b1, w[6:0]};
      default: ;
    endcase
  endtask

  task automatic drive_cycle(input logic valid, input retire_t r, input insn_class_e c,
                             input logic clr);
    violation_t  v;
    logic [31:0] post;
    logic        u;
    logic        illegal;
    v = '0;
    u = (r.mode == MODE_U);
    illegal = r.trap.trap && r.trap.exception && (r.trap.cause == EXC_ILLEGAL);
    post = (r.mstatus_wdata & r.mstatus_wmask) | (r.mstatus_rdata & ~r.mstatus_wmask);
    if (valid) begin
      v[RULE_MODE_SUPPORTED] = (r.mode == MODE_S) || (r.mode == MODE_R);
      v[RULE_MSCRATCH] = u && (r.mscratch_wmask != 32'h0);
      v[RULE_MPP_LEGAL] = (post[MPP_POS +: 2] == 2'b01) || (post[MPP_POS +: 2] == 2'b10);
      v[RULE_UMODE_MPRV] = u && r.mstatus_rdata[MPRV_POS];
      v[RULE_WFI_TW] = u && (c == CLASS_WFI) && (illegal != r.mstatus_rdata[TW_POS]);
      v[RULE_ECALL] = u && (c == CLASS_ECALL) &&
                      !(r.trap.trap && r.trap.exception && (r.trap.cause == EXC_ECALL_U));
      v[RULE_MUST_ILLEGAL] = !illegal && ((c == CLASS_URET) || (c == CLASS_CUSTOM) ||
                             (u && ((c == CLASS_MRET) || (c == CLASS_CSR_HIGH))));
      v[RULE_TRAP_TO_M] = m_prev_trap && (r.mode != MODE_M);
      v[RULE_MRET_TO_MPP] = m_prev_mret && (r.mode != m_prev_mpp);
      m_prev_trap = r.trap.trap;
      m_prev_mret = (c == CLASS_MRET) && (r.mode == MODE_M) && !r.trap.trap;
      m_prev_mpp = priv_mode_e'(r.mstatus_rdata[MPP_POS +: 2]);
    end
    exp_viol = v;
    exp_sticky = (clr ? '0 : exp_sticky) | v;
    if (clr) exp_count = '0;
    if ((v != '0) && (exp_count != '1)) exp_count = exp_count + 1'b1;
    retire_valid = valid;
    retire = r;
    log_clear = clr;
    @(posedge clk_i);
    #1;
    assert ((violation == exp_viol) && (violation_sticky == exp_sticky) &&
            (violation_count == exp_count)) else begin
      $display("Fail at %0t ns: got %b/%b/%0d, expected %b/%b/%0d", $time, violation,
               violation_sticky, violation_count, exp_viol, exp_sticky, exp_count);
      test_errors++;
    end
  endtask

  task automatic idle_cycles(input int n);
    retire_t junk;
    // would break several rules if it were valid
    junk = '0;
    junk.mode = MODE_S;
    junk.insn = URET_IDATA;
    repeat (n) drive_cycle(1'b0, junk, CLASS_URET, 1'b0);
  endtask

  task automatic inject_rule(input int rule, input logic clr);
    retire_t     r;
    insn_class_e c;
    logic [1:0]  k;
    // clean machine record so the history rules stay quiet
    gen_legal(MODE_M, 0, r, c);
    drive_cycle(1'b1, r, c, 1'b0);
    gen_legal((rule == 0 || rule == 2) ? MODE_M : MODE_U,
              (rule == 4) ? 3 : (rule == 5) ? 2 : 0, r, c);
    k = rand_bits(2);
    case (rule)
      0: r.mode = k[0] ? MODE_S : MODE_R;
      1: r.mscratch_wmask = rand_bits(32) | 32'h1;
      2: begin
        r.mstatus_wmask[MPP_POS +: 2] = 2'b11;
        r.mstatus_wdata[MPP_POS +: 2] = k[0] ? 2'b01 : 2'b10;
      end
      3: r.mstatus_rdata[MPRV_POS] = 1'b1;
      4: r.trap = r.trap.trap ? 8'h00 : {2'b11, EXC_ILLEGAL};
      5: r.trap.cause = EXC_ILLEGAL;
      default: begin
        r.insn = (k == 0) ? URET_IDATA : (k == 1) ? CUSTOM0_IDATA :
                 (k == 2) ? MRET_IDATA : 32'h30012073;
        c = (k == 0) ? CLASS_URET : (k == 1) ? CLASS_CUSTOM :
            (k == 2) ? CLASS_MRET : CLASS_CSR_HIGH;
      end
    endcase
    drive_cycle(1'b1, r, c, clr);
  endtask

  task automatic check_only(input int rule);
    assert (violation == (violation_t'(1) << rule)) else begin
      $display("Fail at %0t ns: expected only rule %0d, got %b", $time, rule, violation);
      test_errors++;
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (test_errors != 0) tests_failed++;
    $display("%s: %s, %0d errors", name, (test_errors == 0) ? "ok" : "failed", test_errors);
    test_errors = 0;
  endtask

  initial begin
    int          i;
    int          prop_failures;
    retire_t     r;
    insn_class_e c;
    repeat (2) @(posedge clk_i);
    #1;
    reset = 1'b0;

    for (i = 0; i < N_LEGAL; i++) begin
      gen_legal(-1, -1, r, c);
      drive_cycle(1'b1, r, c, 1'b0);
      idle_cycles(rand_bits(2));
    end
    assert ((violation_sticky == '0) && (violation_count == '0)) else begin
      $display("Fail at %0t ns: legal records left sticky or count set", $time);
      test_errors++;
    end
    end_test("legal records");

    for (i = 0; i < 7; i++) begin
      inject_rule(i, 1'b0);
      check_only(i);
    end
    for (i = 0; i < N_INJECT; i++) inject_rule(rand_bits(3) % 7, 1'b0);
    end_test("single rule injection");

    for (i = 0; i < N_CROSS; i++) begin
      gen_legal(MODE_M, 7, r, c);
      drive_cycle(1'b1, r, c, 1'b0);
      idle_cycles(rand_bits(2));
      gen_legal(MODE_U, 0, r, c);
      drive_cycle(1'b1, r, c, 1'b0);
      check_only(RULE_TRAP_TO_M);
      // machine mret that returns to user mode
      gen_legal(MODE_M, 4, r, c);
      r.mstatus_rdata[MPP_POS +: 2] = 2'b00;
      drive_cycle(1'b1, r, c, 1'b0);
      idle_cycles(rand_bits(2));
      gen_legal(MODE_M, 0, r, c);
      drive_cycle(1'b1, r, c, 1'b0);
      check_only(RULE_MRET_TO_MPP);
    end
    end_test("cross retirement rules");

    for (i = 0; i < N_LONG; i++) begin
      idle_cycles(rand_bits(1) ? 0 : rand_bits(2));
      if (rand_bits(3) == 0) inject_rule(rand_bits(3) % 7, rand_bits(4) == 0);
      else begin
        gen_legal(-1, -1, r, c);
        drive_cycle(1'b1, r, c, rand_bits(4) == 0);
      end
    end
    inject_rule(RULE_UMODE_MPRV, 1'b1);
    assert ((violation_sticky == (violation_t'(1) << RULE_UMODE_MPRV)) &&
            (violation_count == 1)) else begin
      $display("Fail at %0t ns: clear lost the violation at the same edge", $time);
      test_errors++;
    end
    end_test("sticky and count");

    gen_legal(MODE_M, 0, r, c);
    r.mode = MODE_S;
    for (i = 0; i < N_SAT; i++) drive_cycle(1'b1, r, c, i == 0);
    assert (violation_count == '1) else begin
      $display("Fail at %0t ns: count %0d did not saturate", $time, violation_count);
      test_errors++;
    end
    end_test("count saturation");

    prop_failures = i_dut.i_violation_log.i_properties.failures;
    $display("%0d tests run, %0d failed, %0d property failures", tests_run, tests_failed,
             prop_failures);
    if ((tests_failed == 0) && (prop_failures == 0)) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/umode_checker_properties.sv
`timescale 1ns/1ps
`default_nettype none

module umode_checker_properties (
  input wire logic                          clk_i,
  input wire logic                          reset,
  input wire logic                          log_clear,
  input wire umode_pkg::violation_t         violation,
  input wire umode_pkg::violation_t         violation_sticky,
  input wire logic [umode_pkg::COUNT_W-1:0] violation_count
);

  int failures = 0;

  // nothing reported straight out of reset
  assert property (@(posedge clk_i) reset |=> (violation == '0))
    else begin
      $error("violation set in the cycle after reset");
      failures++;
    end

  assert property (@(posedge clk_i) disable iff (reset)
                   ((violation & ~violation_sticky) == '0))
    else begin
      $error("sticky flags miss a reported violation");
      failures++;
    end

  // only a clear may bring the count down
  assert property (@(posedge clk_i) disable iff (reset)
                   (!$past(reset) && !$past(log_clear)) |->
                   (violation_count >= $past(violation_count)))
    else begin
      $error("violation count decreased without a clear");
      failures++;
    end

endmodule

bind violation_log umode_checker_properties i_properties (
  .clk_i            (clk_i),
  .reset            (reset),
  .log_clear        (log_clear),
  .violation        (violation),
  .violation_sticky (violation_sticky),
  .violation_count  (violation_count)
);

`default_nettype wire

//--- verilog.f
source/umode_pkg.sv
source/insn_decoder.sv
source/rule_checker.sv
source/mode_tracker.sv
source/violation_log.sv
source/umode_checker.sv
testbench/umode_checker_properties.sv
testbench/tb_umode_checker.sv
